/* Bender.yml */
package:
  name: emu_io_core

sources:
  # Package and interface come first, the blocks depend on them
  - source/emu_pkg.sv
  - source/mem_port_if.sv
  - source/host_reset_seq.sv
  - source/disk_dma_bridge.sv
  - source/activity_led.sv
  - source/emu_io_core.sv

  - target: test
    files:
      - bench/mem_responder.sv
      - bench/emu_io_core_tb.sv

/* bench/emu_io_core_tb.sv */
/*
 * Random disk DMA traffic checked against a word model, plus reset and LED timing.
 * LED hold is cut to 20 cycles; stimulus changes on the falling clock edge.
 */

`timescale 1ns/1ps

module emu_io_core_tb;

	localparam int led_hold   = 20;
	localparam int num_xfers  = 300;
	localparam int timeout_ns = (num_xfers * 40 + 100) * 4;

	logic           clk_sys;
	logic           reset;
	logic           status_reset;
	logic           button_reset;
	logic           ps2_reset_n;
	logic           sys_reset;
	logic           cpu_reset;
	logic           dma_rd;
	logic           dma_wr;
	emu_pkg::addr_t dma_addr;
	emu_pkg::data_t dma_dout;
	emu_pkg::data_t dma_din;
	logic           dma_busy;
	logic           disk_device;
	emu_pkg::addr_t mem_address;
	emu_pkg::data_t mem_writedata;
	logic           mem_read;
	logic           mem_write;
	logic           mem_waitrequest;
	emu_pkg::data_t mem_readdata;
	logic           mem_readdatavalid;
	logic           led_hdd;
	logic           led_fdd;

	// Model memory and the transfer now in flight
	emu_pkg::data_t model_mem [64];
	emu_pkg::addr_t addr_pool [32];
	emu_pkg::data_t last_read;
	emu_pkg::addr_t exp_addr;
	emu_pkg::data_t exp_data;
	logic           exp_write;
	int             accepts = 0;
	int             hdd_age = led_hold;
	int             fdd_age = led_hold;
	logic           held_read;
	logic           held_write;
	emu_pkg::addr_t held_addr;
	emu_pkg::data_t held_data;

	emu_io_core #(.led_hold_cycles(led_hold)) i_dut (.*);

	mem_responder i_mem (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.address       (mem_address),
		.writedata     (mem_writedata),
		.read          (mem_read),
		.write         (mem_write),
		.waitrequest   (mem_waitrequest),
		.readdata      (mem_readdata),
		.readdatavalid (mem_readdatavalid)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	// ==============================
	// Failure reporting
	// ==============================

	task automatic abort_run(input string why);
		$display("Run stopped: %s", why);
		$display("Finished with errors");
		$fatal(1, "%s", why);
	endtask

	task automatic compare_word(input string name, input emu_pkg::data_t got,
		input emu_pkg::data_t exp);
		if (got !== exp) begin
			$display("[ERROR] at %0d ns %s: got %h, expected %h", $time, name, got, exp);
			abort_run("data word mismatch");
		end
	endtask

	task automatic expect_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] at %0d ns %s: got %b, expected %b", $time, name, got, exp);
			abort_run("signal level mismatch");
		end
	endtask

	task automatic match_address(input string name, input emu_pkg::addr_t got,
		input emu_pkg::addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] at %0d ns %s: got %h, expected %h", $time, name, got, exp);
			abort_run("address mismatch");
		end
	endtask

	function automatic emu_pkg::data_t fill_word(input int idx);
		return 32'hd15c_0000 ^ (32'(idx) * 32'h0001_0203);
	endfunction

	// ==============================
	// Bus and LED monitors
	// ==============================

	// Sampled at the rising edge where the DUT and memory sample too
	always @(posedge clk_sys) begin
		if (reset !== 1'b1) begin
			if (mem_read === 1'b1 && mem_write === 1'b1)
				abort_run("memory read and write are high in the same cycle");
			if (held_read)
				expect_level("mem_read", mem_read, 1'b1);
			if (held_write) begin
				expect_level("mem_write", mem_write, 1'b1);
				compare_word("mem_writedata", mem_writedata, held_data);
			end
			if (held_read || held_write)
				match_address("mem_address", mem_address, held_addr);
			if ((mem_read === 1'b1 || mem_write === 1'b1) && mem_waitrequest === 1'b0) begin
				accepts++;
				expect_level("mem_write", mem_write, exp_write);
				match_address("mem_address", mem_address, exp_addr);
				if (mem_write)
					compare_word("mem_writedata", mem_writedata, exp_data);
			end
		end
		held_read  = (reset !== 1'b1) && mem_read === 1'b1 && mem_waitrequest === 1'b1;
		held_write = (reset !== 1'b1) && mem_write === 1'b1 && mem_waitrequest === 1'b1;
		held_addr  = mem_address;
		held_data  = mem_writedata;
	end

	// Lamp is on while fewer than led_hold edges passed since its input was high
	always @(posedge clk_sys) begin
		if (reset !== 1'b1) begin
			expect_level("led_hdd", led_hdd, hdd_age < led_hold);
			expect_level("led_fdd", led_fdd, fdd_age < led_hold);
		end
		if (reset === 1'b1)
			hdd_age = led_hold;
		else if (dma_busy && disk_device)
			hdd_age = 0;
		else if (hdd_age < led_hold)
			hdd_age++;
		if (reset === 1'b1)
			fdd_age = led_hold;
		else if (dma_busy && !disk_device)
			fdd_age = 0;
		else if (fdd_age < led_hold)
			fdd_age++;
	end

	initial begin
		#(timeout_ns);
		abort_run("watchdog expired before all tests completed");
	end

	// ==============================
	// Stimulus
	// ==============================

	task automatic menu_reset_sequence(input bit first);
		logic exp_sys;

		for (int k = 0; k < 4; k++) begin
			@(negedge clk_sys);
			expect_level("sys_reset", sys_reset, first);
			expect_level("cpu_reset", cpu_reset, first);
		end
		status_reset = 1'b1;
		// Stretch starts after two sync flops and the edge register
		for (int k = 1; k <= emu_pkg::rst_stretch + 4; k++) begin
			@(negedge clk_sys);
			status_reset = 1'b0;
			exp_sys = (first || k >= 3) && (k < 3 + emu_pkg::rst_stretch);
			expect_level("sys_reset", sys_reset, exp_sys);
			expect_level("cpu_reset", cpu_reset, exp_sys | (k == 1));
		end
	endtask

	task automatic cpu_reset_follows(input bit use_button);
		@(negedge clk_sys);
		if (use_button)
			button_reset = 1'b1;
		else
			ps2_reset_n = 1'b0;
		#1;
		expect_level("cpu_reset", cpu_reset, 1'b0);
		@(negedge clk_sys);
		expect_level("cpu_reset", cpu_reset, 1'b1);
		expect_level("sys_reset", sys_reset, 1'b0);
		button_reset = 1'b0;
		ps2_reset_n  = 1'b1;
		@(negedge clk_sys);
		expect_level("cpu_reset", cpu_reset, 1'b0);
	endtask

	task automatic do_transfer(input bit is_write, input emu_pkg::addr_t addr,
		input emu_pkg::data_t data, input bit dev);
		expect_level("dma_busy", dma_busy, 1'b0);
		exp_write   = is_write;
		exp_addr    = addr;
		exp_data    = data;
		accepts     = 0;
		dma_addr    = addr;
		dma_dout    = data;
		disk_device = dev;
		dma_rd      = ~is_write;
		dma_wr      = is_write;
		@(negedge clk_sys);
		dma_rd = 1'b0;
		dma_wr = 1'b0;
		expect_level("dma_busy", dma_busy, 1'b1);
		while (dma_busy === 1'b1)
			@(negedge clk_sys);
		if (accepts != 1)
			abort_run($sformatf("transfer to %h gave %0d memory commands", addr, accepts));
		if (is_write)
			model_mem[addr[5:0]] = data;
		else
			last_read = model_mem[addr[5:0]];
		compare_word("dma_din", dma_din, last_read);
	endtask

	initial begin
		bit             is_write;
		bit             dev;
		emu_pkg::addr_t addr;
		emu_pkg::data_t data;

		void'($urandom(32'h65c41b94));
		reset        = 1'b1;
		status_reset = 1'b0;
		button_reset = 1'b0;
		ps2_reset_n  = 1'b1;
		dma_rd       = 1'b0;
		dma_wr       = 1'b0;
		dma_addr     = '0;
		dma_dout     = '0;
		disk_device  = 1'b0;
		last_read    = '0;
		for (int i = 0; i < 64; i++)
			model_mem[i] = fill_word(i);
		// Distinct low index bits, so no two pool entries share a word
		for (int k = 0; k < 32; k++)
			addr_pool[k] = ($urandom() & 32'hffff_ffc0) | 32'(2 * k + $urandom_range(0, 1));

		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		expect_level("dma_busy", dma_busy, 1'b0);
		compare_word("dma_din", dma_din, '0);
		expect_level("mem_read", mem_read, 1'b0);
		expect_level("mem_write", mem_write, 1'b0);
		expect_level("sys_reset", sys_reset, 1'b1);

		menu_reset_sequence(1'b1);
		menu_reset_sequence(1'b0);
		cpu_reset_follows(1'b1);
		cpu_reset_follows(1'b0);

		for (int t = 0; t < num_xfers; t++) begin
			repeat ($urandom_range(0, 5)) @(negedge clk_sys);
			is_write = $urandom_range(0, 1);
			dev      = $urandom_range(0, 1);
			addr     = addr_pool[$urandom_range(0, 31)];
			data     = $urandom();
			do_transfer(is_write, addr, data, dev);
		end

		// Let both lamps run out under the monitor
		repeat (led_hold + 5) @(negedge clk_sys);
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* bench/mem_responder.sv */
/*
 * Memory model with random stalls and a random read latency of 1 to 6 cycles.
 * 64 words indexed by address[5:0], one outstanding read at a time.
 */

`timescale 1ns/1ps

module mem_responder (
	input  logic           clk_sys,
	input  logic           reset,
	input  emu_pkg::addr_t address,
	input  emu_pkg::data_t writedata,
	input  logic           read,
	input  logic           write,
	output logic           waitrequest,
	output emu_pkg::data_t readdata,
	output logic           readdatavalid
);

	emu_pkg::data_t words [64];
	emu_pkg::data_t read_word;
	logic           read_pending;
	int             read_delay;

	// Power-up contents, every word differs with its index
	initial begin
		for (int i = 0; i < 64; i++)
			words[i] = 32'hd15c_0000 ^ (32'(i) * 32'h0001_0203);
		read_word     = '0;
		read_pending  = 1'b0;
		read_delay    = 0;
		waitrequest   = 1'b1;
		readdata      = '0;
		readdatavalid = 1'b0;
	end

	// Acceptance is a command seen with waitrequest low at the rising edge
	always @(posedge clk_sys) begin
		if (reset) begin
			read_pending = 1'b0;
		end else begin
			if (write && !waitrequest)
				words[address[5:0]] = writedata;
			if (read && !waitrequest) begin
				read_word    = words[address[5:0]];
				read_delay   = $urandom_range(1, 6);
				read_pending = 1'b1;
			end
		end
	end

	// ==============================
	// Response side
	// ==============================

	always @(negedge clk_sys) begin
		waitrequest   <= ($urandom_range(0, 2) == 0);
		readdata      <= $urandom();
		readdatavalid <= 1'b0;
		if (read_pending) begin
			read_delay = read_delay - 1;
			if (read_delay == 0) begin
				readdata      <= read_word;
				readdatavalid <= 1'b1;
				read_pending   = 1'b0;
			end
		end
	end

endmodule

/* emu_io_core.f */
source/emu_pkg.sv
source/mem_port_if.sv
source/host_reset_seq.sv
source/disk_dma_bridge.sv
source/activity_led.sv
source/emu_io_core.sv
bench/mem_responder.sv
bench/emu_io_core_tb.sv

/* source/activity_led.sv */
/*
 * Retriggerable stretcher for a disk activity LED.
 * The lamp stays on hold_cycles cycles after active was last high.
 */

`timescale 1ns/1ps

module activity_led #(
	parameter int hold_cycles = emu_pkg::led_hold_default
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic active,
	output logic lamp
);

	// At least one bit, so short holds still elaborate
	localparam int cnt_w = (hold_cycles > 1) ? $clog2(hold_cycles + 1) : 1;

	logic [cnt_w-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
			lamp  <= 1'b0;
		end else begin
			if (active)
				count <= cnt_w'(hold_cycles);
			else if (count != '0)
				count <= count - 1'b1;

			// Lamp leads the counter by one cycle so the on time is exact
			lamp <= active | (count > cnt_w'(1));
		end
	end

endmodule

/* source/disk_dma_bridge.sv */
/*
 * Turns single-cycle host disk strobes into one memory read or write each.
 * The host must wait for dma_busy low before the next strobe.
 */

`timescale 1ns/1ps

module disk_dma_bridge (
	input  logic           clk_sys,
	input  logic           reset,
	input  logic           dma_rd,
	input  logic           dma_wr,
	input  emu_pkg::addr_t dma_addr,
	input  emu_pkg::data_t dma_dout,
	output emu_pkg::data_t dma_din,
	output logic           dma_busy,
	mem_port_if.master     mem
);

	emu_pkg::bridge_state_t state;

	logic host_req;

	assign host_req = dma_rd | dma_wr;

	// Busy covers every state but idle, so it rises the cycle after a strobe
	assign dma_busy = (state != emu_pkg::idle);

	// ==============================
	// Command payload
	// ==============================

	// Captured once per transfer and held until the next strobe
	always_ff @(posedge clk_sys) begin
		if (state == emu_pkg::idle && host_req) begin
			mem.address <= dma_addr;
			if (dma_wr && !dma_rd)
				mem.writedata <= dma_dout;
		end
	end

	// ==============================
	// Transfer FSM
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= emu_pkg::idle;
			mem.read  <= 1'b0;
			mem.write <= 1'b0;
			dma_din   <= '0;
		end else begin
			case (state)
				emu_pkg::idle: begin
					// Read wins if both strobes ever come together
					if (dma_rd)
						state <= emu_pkg::read_issue;
					else if (dma_wr)
						state <= emu_pkg::write_issue;
				end

				emu_pkg::read_issue: begin
					if (!mem.waitrequest) begin
						mem.read <= 1'b1;
						state    <= emu_pkg::read_wait;
					end
				end

				emu_pkg::read_wait: begin
					// Drop the command once accepted, then wait for the data
					if (mem.read && !mem.waitrequest)
						mem.read <= 1'b0;
					if (mem.readdatavalid) begin
						dma_din <= mem.readdata;
						state   <= emu_pkg::idle;
					end
				end

				emu_pkg::write_issue: begin
					if (!mem.waitrequest) begin
						mem.write <= 1'b1;
						state     <= emu_pkg::write_done;
					end
				end

				emu_pkg::write_done: begin
					// Write is complete on acceptance, no response expected
					if (!mem.waitrequest) begin
						mem.write <= 1'b0;
						state     <= emu_pkg::idle;
					end
				end

				default: state <= emu_pkg::idle;
			endcase
		end
	end

	// ==============================
	// Protocol checks
	// ==============================

	a_no_rd_wr_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem.read && mem.write));

	a_read_held: assert property (@(posedge clk_sys) disable iff (reset)
		mem.read && mem.waitrequest |=> mem.read && $stable(mem.address));

	a_write_held: assert property (@(posedge clk_sys) disable iff (reset)
		mem.write && mem.waitrequest |=>
			mem.write && $stable(mem.address) && $stable(mem.writedata));

	a_no_strobe_when_busy: assert property (@(posedge clk_sys) disable iff (reset)
		dma_busy |-> !host_req);

endmodule

/* source/emu_io_core.sv */
/*
 * Stateful part of the board wrapper: resets, disk DMA bridge, disk LEDs.
 * All blocks share clk_sys and the synchronous board reset.
 */

`timescale 1ns/1ps

module emu_io_core #(
	parameter int led_hold_cycles = emu_pkg::led_hold_default
) (
	input  logic           clk_sys,
	input  logic           reset,

	// Reset sources
	input  logic           status_reset,
	input  logic           button_reset,
	input  logic           ps2_reset_n,
	output logic           sys_reset,
	output logic           cpu_reset,

	// Host disk DMA
	input  logic           dma_rd,
	input  logic           dma_wr,
	input  emu_pkg::addr_t dma_addr,
	input  emu_pkg::data_t dma_dout,
	output emu_pkg::data_t dma_din,
	output logic           dma_busy,
	input  logic           disk_device,

	// Memory port
	output emu_pkg::addr_t mem_address,
	output emu_pkg::data_t mem_writedata,
	output logic           mem_read,
	output logic           mem_write,
	input  logic           mem_waitrequest,
	input  emu_pkg::data_t mem_readdata,
	input  logic           mem_readdatavalid,

	// Activity lamps
	output logic           led_hdd,
	output logic           led_fdd
);

	mem_port_if mem_bus ();

	logic hdd_active;
	logic fdd_active;

	// ==============================
	// Reset sequencing
	// ==============================

	host_reset_seq i_reset_seq (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.ps2_reset_n  (ps2_reset_n),
		.sys_reset    (sys_reset),
		.cpu_reset    (cpu_reset)
	);

	// ==============================
	// Disk DMA
	// ==============================

	disk_dma_bridge i_dma_bridge (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dma_rd   (dma_rd),
		.dma_wr   (dma_wr),
		.dma_addr (dma_addr),
		.dma_dout (dma_dout),
		.dma_din  (dma_din),
		.dma_busy (dma_busy),
		.mem      (mem_bus.master)
	);

	assign mem_address   = mem_bus.address;
	assign mem_writedata = mem_bus.writedata;
	assign mem_read      = mem_bus.read;
	assign mem_write     = mem_bus.write;

	assign mem_bus.waitrequest   = mem_waitrequest;
	assign mem_bus.readdata      = mem_readdata;
	assign mem_bus.readdatavalid = mem_readdatavalid;

	// ==============================
	// Disk LEDs
	// ==============================

	// disk_device picks which lamp shows the current transfer
	assign hdd_active = dma_busy & disk_device;
	assign fdd_active = dma_busy & ~disk_device;

	activity_led #(.hold_cycles(led_hold_cycles)) i_led_hdd (
		.clk_sys (clk_sys),
		.reset   (reset),
		.active  (hdd_active),
		.lamp    (led_hdd)
	);

	activity_led #(.hold_cycles(led_hold_cycles)) i_led_fdd (
		.clk_sys (clk_sys),
		.reset   (reset),
		.active  (fdd_active),
		.lamp    (led_fdd)
	);

endmodule

/* source/emu_pkg.sv */
/*
 * Shared widths and constants for the host-side glue of the PC core.
 * Word addresses only, no byte enables. LED hold assumes a 50 MHz clk_sys.
 */

package emu_pkg;

	// ==============================
	// Bus widths
	// ==============================

	// Word address of the disk DMA window and of the memory port
	localparam int addr_w = 32;

	// One memory word, no byte lanes
	localparam int data_w = 32;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;

	// ==============================
	// Timing constants
	// ==============================

	// System reset is held this many cycles after a menu reset edge
	localparam int rst_stretch = 8;

	// Roughly 90 ms at 50 MHz
	localparam int led_hold_default = 4_500_000;

	// ==============================
	// DMA bridge FSM
	// ==============================

	typedef enum logic [2:0] {
		idle,
		read_issue,
		read_wait,
		write_issue,
		write_done
	} bridge_state_t;

endpackage

/* source/host_reset_seq.sv */
/*
 * Builds system and CPU reset from the menu, button and keyboard sources.
 * sys_reset stays high until the first menu reset request has run its stretch.
 */

`timescale 1ns/1ps

module host_reset_seq (
	input  logic clk_sys,
	input  logic reset,
	input  logic status_reset,
	input  logic button_reset,
	input  logic ps2_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);

	logic [1:0]                     req_sync;
	logic                           req_prev;
	logic                           req_edge;
	logic [emu_pkg::rst_stretch-1:0] stretch_q;
	logic                           started;
	logic                           cpu_req_q;

	// Rising edge of the synchronized menu request
	assign req_edge = req_sync[1] & ~req_prev;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_sync  <= '0;
			req_prev  <= 1'b0;
			stretch_q <= '0;
			started   <= 1'b0;
			cpu_req_q <= 1'b0;
		end else begin
			req_sync <= {req_sync[0], status_reset};
			req_prev <= req_sync[1];

			// Load all ones and shift left so the MSB carries the stretched pulse
			if (req_edge) begin
				stretch_q <= '1;
				started   <= 1'b1;
			end else begin
				stretch_q <= stretch_q << 1;
			end

			cpu_req_q <= button_reset | status_reset | ~ps2_reset_n;
		end
	end

	assign sys_reset = reset | ~started | stretch_q[emu_pkg::rst_stretch-1];
	assign cpu_reset = sys_reset | cpu_req_q;

	// A menu edge holds the system for the whole stretch
	a_stretch_len: assert property (@(posedge clk_sys) disable iff (reset)
		req_edge |=> sys_reset [*emu_pkg::rst_stretch]);

endmodule

/* source/mem_port_if.sv */
/*
 * Single-word memory port with wait-request and read-data-valid.
 * One command at a time; no bursts and no byte enables.
 */

`timescale 1ns/1ps

interface mem_port_if;

	// Command side, driven by the bridge
	emu_pkg::addr_t address;
	emu_pkg::data_t writedata;
	logic           read;
	logic           write;

	// Response side, driven by the memory
	logic           waitrequest;
	emu_pkg::data_t readdata;
	logic           readdatavalid;

	modport master (
		output address, writedata, read, write,
		input  waitrequest, readdata, readdatavalid
	);

	modport slave (
		input  address, writedata, read, write,
		output waitrequest, readdata, readdatavalid
	);

endinterface
